//--- all.f
+incdir+hdl
hdl/gcn_isa_pkg.sv
hdl/simd_decode_pkg.sv
hdl/operand_select_decode.sv
hdl/wr_enable_decode.sv
hdl/decode_issue_stage.sv
hdl/simd_instr_decoder.sv
verification/decode_checker.sv
verification/tb_simd_instr_decoder.sv

//--- hdl/decode_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "simd_decode_settings.svh"

module decode_issue_stage
  import simd_decode_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  output logic     instr_ready,
  input  logic     credit_return,
  output logic     out_valid,
  input  logic     vcc_wr_en_d,
  input  logic     vgpr_wr_en_d,
  input  logic     sgpr_wr_en_d,
  input  logic     illegal_instr_d,
  input  src_sel_e source1_mux_select_d,
  input  src_sel_e source2_mux_select_d,
  input  src_sel_e source3_mux_select_d,
  input  logic     vgpr_source1_rd_en_d,
  input  logic     vgpr_source2_rd_en_d,
  input  logic     vgpr_source3_rd_en_d,
  output logic     vcc_wr_en,
  output logic     vgpr_wr_en,
  output logic     sgpr_wr_en,
  output logic     illegal_instr,
  output src_sel_e source1_mux_select,
  output src_sel_e source2_mux_select,
  output src_sel_e source3_mux_select,
  output logic     vgpr_source1_rd_en,
  output logic     vgpr_source2_rd_en,
  output logic     vgpr_source3_rd_en
);

  localparam int credit_w = $clog2(`SIMD_CREDITS + 1);

  logic [credit_w-1:0] credit_cnt;
  logic                accept;

  assign instr_ready = (credit_cnt != '0); // Stall when downstream is full
  assign accept      = instr_valid && instr_ready;

  // Return and acceptance in one cycle cancel out
  always_ff @(posedge clk)
  begin
    if (reset)
      credit_cnt <= credit_w'(`SIMD_CREDITS);
    else if (accept && !credit_return)
      credit_cnt <= credit_cnt - 1'b1;
    else if (!accept && credit_return)
      credit_cnt <= credit_cnt + 1'b1;
  end

  // Enables are single cycle pulses
  always_ff @(posedge clk)
  begin
    if (reset || !accept)
    begin
      out_valid          <= 1'b0;
      vcc_wr_en          <= 1'b0;
      vgpr_wr_en         <= 1'b0;
      sgpr_wr_en         <= 1'b0;
      illegal_instr      <= 1'b0;
      vgpr_source1_rd_en <= 1'b0;
      vgpr_source2_rd_en <= 1'b0;
      vgpr_source3_rd_en <= 1'b0;
    end
    else
    begin
      out_valid          <= 1'b1;
      vcc_wr_en          <= vcc_wr_en_d;
      vgpr_wr_en         <= vgpr_wr_en_d;
      sgpr_wr_en         <= sgpr_wr_en_d;
      illegal_instr      <= illegal_instr_d;
      vgpr_source1_rd_en <= vgpr_source1_rd_en_d;
      vgpr_source2_rd_en <= vgpr_source2_rd_en_d;
      vgpr_source3_rd_en <= vgpr_source3_rd_en_d;
    end
  end

  // Selects hold their last value between results
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      source1_mux_select <= source1_mux_select_d;
      source2_mux_select <= source2_mux_select_d;
      source3_mux_select <= source3_mux_select_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/gcn_isa_pkg.sv
`default_nettype none

package gcn_isa_pkg;

  // Format codes live in the top byte of the instruction
  localparam logic [7:0] fmt_vop1  = 8'h01;
  localparam logic [7:0] fmt_vop2  = 8'h02;
  localparam logic [7:0] fmt_vopc  = 8'h03;
  localparam logic [7:0] fmt_vop3a = 8'h04;

  localparam logic [11:0] op_v_cndmask_b32  = 12'h000;
  localparam logic [11:0] op_v_mov_b32      = 12'h001; // VOP1 only
  localparam logic [11:0] op_v_mul_i32_i24  = 12'h009;
  localparam logic [11:0] op_v_max_i32      = 12'h012;
  localparam logic [11:0] op_v_min_u32      = 12'h013;
  localparam logic [11:0] op_v_max_u32      = 12'h014;
  localparam logic [11:0] op_v_lshrrev_b32  = 12'h016;
  localparam logic [11:0] op_v_ashrrev_i32  = 12'h018;
  localparam logic [11:0] op_v_lshlrev_b32  = 12'h01A;
  localparam logic [11:0] op_v_and_b32      = 12'h01B;
  localparam logic [11:0] op_v_or_b32       = 12'h01C;
  localparam logic [11:0] op_v_add_i32      = 12'h025; // Carry out to VCC
  localparam logic [11:0] op_v_sub_i32      = 12'h026;
  localparam logic [11:0] op_v_subrev_i32   = 12'h027;
  localparam logic [11:0] op_v_addc_u32     = 12'h028;

  // VOP3A encodings of the vector ops
  localparam logic [11:0] op_v3_mul_i32_i24 = 12'h109;
  localparam logic [11:0] op_v3_min_u32     = 12'h113;
  localparam logic [11:0] op_v3_max_u32     = 12'h114;
  localparam logic [11:0] op_v3_and_b32     = 12'h11B;
  localparam logic [11:0] op_v3_bfe_u32     = 12'h148;
  localparam logic [11:0] op_v3_bfe_i32     = 12'h149;
  localparam logic [11:0] op_v3_bfi_b32     = 12'h14A;
  localparam logic [11:0] op_v3_mul_lo_u32  = 12'h169;
  localparam logic [11:0] op_v3_mul_hi_u32  = 12'h16A;
  localparam logic [11:0] op_v3_mul_lo_i32  = 12'h16B;

  // Integer compares, same code in VOPC and VOP3A
  localparam logic [11:0] op_v_cmp_f_i32    = 12'h080;
  localparam logic [11:0] op_v_cmp_lt_i32   = 12'h081;
  localparam logic [11:0] op_v_cmp_eq_i32   = 12'h082;
  localparam logic [11:0] op_v_cmp_le_i32   = 12'h083;
  localparam logic [11:0] op_v_cmp_gt_i32   = 12'h084;
  localparam logic [11:0] op_v_cmp_lg_i32   = 12'h085;
  localparam logic [11:0] op_v_cmp_ge_i32   = 12'h086;
  localparam logic [11:0] op_v_cmp_tru_i32  = 12'h087;
  localparam logic [11:0] op_v_cmp_f_u32    = 12'h0C0;
  localparam logic [11:0] op_v_cmp_lt_u32   = 12'h0C1;
  localparam logic [11:0] op_v_cmp_eq_u32   = 12'h0C2;
  localparam logic [11:0] op_v_cmp_le_u32   = 12'h0C3;
  localparam logic [11:0] op_v_cmp_gt_u32   = 12'h0C4;
  localparam logic [11:0] op_v_cmp_lg_u32   = 12'h0C5;
  localparam logic [11:0] op_v_cmp_ge_u32   = 12'h0C6;
  localparam logic [11:0] op_v_cmp_tru_u32  = 12'h0C7;

  // Special operand addresses, one hot in the low byte
  localparam logic [11:0] addr_literal = 12'h7FF;
  localparam logic [11:0] addr_vcc_lo  = 12'hE01;
  localparam logic [11:0] addr_vcc_hi  = 12'hE02;
  localparam logic [11:0] addr_m0      = 12'hE04;
  localparam logic [11:0] addr_exec_lo = 12'hE08;
  localparam logic [11:0] addr_exec_hi = 12'hE10;
  localparam logic [11:0] addr_vccz    = 12'hE20;
  localparam logic [11:0] addr_execz   = 12'hE40;
  localparam logic [11:0] addr_scc     = 12'hE80;

  localparam logic [1:0] prefix_const = 2'b00;
  localparam logic [1:0] prefix_vgpr  = 2'b10;
  localparam logic [2:0] prefix_sgpr  = 3'b110;

endpackage

`default_nettype wire

//--- hdl/operand_select_decode.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select_decode
  import gcn_isa_pkg::*;
  import simd_decode_pkg::*;
(
  input  addr_t    source_addr,
  output src_sel_e mux_select,
  output logic     vgpr_rd_en
);

  src_sel_e special_sel;

  // Registers outside the general files
  always_comb
  begin
    case (source_addr)
      addr_vcc_lo:  special_sel = src_vcc_lo;
      addr_vcc_hi:  special_sel = src_vcc_hi;
      addr_m0:      special_sel = src_m0;
      addr_exec_lo: special_sel = src_exec_lo;
      addr_exec_hi: special_sel = src_exec_hi;
      addr_vccz:    special_sel = src_vccz;
      addr_execz:   special_sel = src_execz;
      addr_scc:     special_sel = src_scc;
      default:      special_sel = src_none;
    endcase
  end

  // Literal must win over the class prefixes
  always_comb
  begin
    if (source_addr == addr_literal)
    begin
      mux_select = src_literal;
    end
    else if (source_addr[11:10] == prefix_const)
    begin
      mux_select = src_const; // Inline constant
    end
    else if (source_addr[11:10] == prefix_vgpr)
    begin
      mux_select = src_vgpr;
    end
    else if (source_addr[11:9] == prefix_sgpr)
    begin
      mux_select = src_sgpr;
    end
    else
    begin
      mux_select = special_sel;
    end
  end

  assign vgpr_rd_en = (mux_select == src_vgpr); // Only the VGPR file is read here

endmodule

`default_nettype wire

//--- hdl/simd_decode_pkg.sv
`default_nettype none

`include "simd_decode_settings.svh"

package simd_decode_pkg;

  typedef logic [`SIMD_ADDR_W-1:0] addr_t;
  typedef logic [`SIMD_INSTR_W-1:0] instr_t;

  // Operand mux select seen by the ALU source muxes
  typedef enum logic [3:0] {
    src_literal = 4'd0,
    src_const   = 4'd1,
    src_vgpr    = 4'd2,
    src_sgpr    = 4'd3,
    src_vcc_lo  = 4'd4,
    src_vcc_hi  = 4'd5,
    src_m0      = 4'd6,
    src_exec_lo = 4'd7,
    src_exec_hi = 4'd8,
    src_vccz    = 4'd9,
    src_execz   = 4'd10,
    src_scc     = 4'd11,
    src_none    = 4'd15 // Address outside every class
  } src_sel_e;

endpackage

`default_nettype wire

//--- hdl/simd_decode_settings.svh
`ifndef SIMD_DECODE_SETTINGS_SVH
`define SIMD_DECODE_SETTINGS_SVH

// Operand and destination address width
`define SIMD_ADDR_W 12

// Full instruction word
`define SIMD_INSTR_W 32

// Results that may be outstanding downstream
`define SIMD_CREDITS 4

`endif

//--- hdl/simd_instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module simd_instr_decoder
  import simd_decode_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  output logic     instr_ready,
  input  instr_t   instr,
  input  addr_t    sgpr_dest_addr,
  input  addr_t    source1_addr,
  input  addr_t    source2_addr,
  input  addr_t    source3_addr,
  input  logic     credit_return,
  output logic     out_valid,
  output logic     vcc_wr_en,
  output logic     vgpr_wr_en,
  output logic     sgpr_wr_en,
  output logic     illegal_instr,
  output src_sel_e source1_mux_select,
  output src_sel_e source2_mux_select,
  output src_sel_e source3_mux_select,
  output logic     vgpr_source1_rd_en,
  output logic     vgpr_source2_rd_en,
  output logic     vgpr_source3_rd_en
);

  logic     vcc_wr_en_d;
  logic     vgpr_wr_en_d;
  logic     sgpr_wr_en_d;
  logic     illegal_instr_d;
  src_sel_e source1_mux_select_d;
  src_sel_e source2_mux_select_d;
  src_sel_e source3_mux_select_d;
  logic     vgpr_source1_rd_en_d;
  logic     vgpr_source2_rd_en_d;
  logic     vgpr_source3_rd_en_d;

  wr_enable_decode u_wr_enable_decode (
    .instr          (instr),
    .sgpr_dest_addr (sgpr_dest_addr),
    .vcc_wr_en      (vcc_wr_en_d),
    .vgpr_wr_en     (vgpr_wr_en_d),
    .sgpr_wr_en     (sgpr_wr_en_d),
    .illegal_instr  (illegal_instr_d)
  );

  // One decoder per source operand
  operand_select_decode u_source1_decode (
    .source_addr (source1_addr),
    .mux_select  (source1_mux_select_d),
    .vgpr_rd_en  (vgpr_source1_rd_en_d)
  );

  operand_select_decode u_source2_decode (
    .source_addr (source2_addr),
    .mux_select  (source2_mux_select_d),
    .vgpr_rd_en  (vgpr_source2_rd_en_d)
  );

  operand_select_decode u_source3_decode (
    .source_addr (source3_addr),
    .mux_select  (source3_mux_select_d),
    .vgpr_rd_en  (vgpr_source3_rd_en_d)
  );

  decode_issue_stage u_decode_issue_stage (
    .clk                  (clk),
    .reset                (reset),
    .instr_valid          (instr_valid),
    .instr_ready          (instr_ready),
    .credit_return        (credit_return),
    .out_valid            (out_valid),
    .vcc_wr_en_d          (vcc_wr_en_d),
    .vgpr_wr_en_d         (vgpr_wr_en_d),
    .sgpr_wr_en_d         (sgpr_wr_en_d),
    .illegal_instr_d      (illegal_instr_d),
    .source1_mux_select_d (source1_mux_select_d),
    .source2_mux_select_d (source2_mux_select_d),
    .source3_mux_select_d (source3_mux_select_d),
    .vgpr_source1_rd_en_d (vgpr_source1_rd_en_d),
    .vgpr_source2_rd_en_d (vgpr_source2_rd_en_d),
    .vgpr_source3_rd_en_d (vgpr_source3_rd_en_d),
    .vcc_wr_en            (vcc_wr_en),
    .vgpr_wr_en           (vgpr_wr_en),
    .sgpr_wr_en           (sgpr_wr_en),
    .illegal_instr        (illegal_instr),
    .source1_mux_select   (source1_mux_select),
    .source2_mux_select   (source2_mux_select),
    .source3_mux_select   (source3_mux_select),
    .vgpr_source1_rd_en   (vgpr_source1_rd_en),
    .vgpr_source2_rd_en   (vgpr_source2_rd_en),
    .vgpr_source3_rd_en   (vgpr_source3_rd_en)
  );

endmodule

`default_nettype wire

//--- hdl/wr_enable_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wr_enable_decode
  import gcn_isa_pkg::*;
  import simd_decode_pkg::*;
(
  input  instr_t instr,
  input  addr_t  sgpr_dest_addr,
  output logic   vcc_wr_en,
  output logic   vgpr_wr_en,
  output logic   sgpr_wr_en,
  output logic   illegal_instr
);

  logic [7:0]  fmt;
  logic [11:0] opcode;
  logic        is_cmp;
  logic        tbl_vcc_wr_en;
  logic        tbl_sgpr_wr_en;

  assign fmt    = instr[31:24]; // Bits 23:12 unused here
  assign opcode = instr[11:0];

  assign is_cmp = opcode inside {
    op_v_cmp_f_i32, op_v_cmp_lt_i32, op_v_cmp_eq_i32, op_v_cmp_le_i32,
    op_v_cmp_gt_i32, op_v_cmp_lg_i32, op_v_cmp_ge_i32, op_v_cmp_tru_i32,
    op_v_cmp_f_u32, op_v_cmp_lt_u32, op_v_cmp_eq_u32, op_v_cmp_le_u32,
    op_v_cmp_gt_u32, op_v_cmp_lg_u32, op_v_cmp_ge_u32, op_v_cmp_tru_u32
  };

  // Opcode table
  always_comb
  begin
    tbl_vcc_wr_en  = 1'b0;
    vgpr_wr_en     = 1'b0;
    tbl_sgpr_wr_en = 1'b0;
    illegal_instr  = 1'b0;
    case (fmt)
      fmt_vop1:
        if (opcode == op_v_mov_b32)
          vgpr_wr_en = 1'b1;
        else
          illegal_instr = 1'b1;
      fmt_vop2:
        case (opcode)
          op_v_add_i32, op_v_sub_i32, op_v_subrev_i32, op_v_addc_u32:
          begin
            tbl_vcc_wr_en = 1'b1; // Carry or borrow
            vgpr_wr_en    = 1'b1;
          end
          op_v_cndmask_b32, op_v_mul_i32_i24, op_v_max_i32, op_v_min_u32,
          op_v_max_u32, op_v_lshrrev_b32, op_v_ashrrev_i32, op_v_lshlrev_b32,
          op_v_and_b32, op_v_or_b32:
            vgpr_wr_en = 1'b1;
          default:
            illegal_instr = 1'b1;
        endcase
      fmt_vopc:
        if (is_cmp)
          tbl_vcc_wr_en = 1'b1;
        else
          illegal_instr = 1'b1;
      fmt_vop3a:
        if (is_cmp)
        begin
          tbl_vcc_wr_en  = 1'b1;
          tbl_sgpr_wr_en = 1'b1;
        end
        else if (opcode inside {op_v3_mul_i32_i24, op_v3_min_u32, op_v3_max_u32,
                                op_v3_and_b32, op_v3_bfe_u32, op_v3_bfe_i32,
                                op_v3_bfi_b32, op_v3_mul_lo_u32, op_v3_mul_hi_u32,
                                op_v3_mul_lo_i32})
          vgpr_wr_en = 1'b1;
        else
          illegal_instr = 1'b1;
      default:
        illegal_instr = 1'b1;
    endcase
  end

  // VOP3A carries its own scalar destination, an illegal op still writes nothing
  always_comb
  begin
    vcc_wr_en  = tbl_vcc_wr_en;
    sgpr_wr_en = tbl_sgpr_wr_en;
    if (fmt == fmt_vop3a && !illegal_instr)
    begin
      if (sgpr_dest_addr == addr_vcc_lo)
      begin
        vcc_wr_en  = 1'b1;
        sgpr_wr_en = 1'b0;
      end
      else if (sgpr_dest_addr[11:9] == prefix_sgpr)
      begin
        vcc_wr_en  = 1'b0;
        sgpr_wr_en = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module tb_simd_instr_decoder -o tb_simd_instr_decoder
./obj_dir/tb_simd_instr_decoder > sim.log
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi

//--- verification/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "simd_decode_settings.svh"

module decode_checker
  import simd_decode_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  logic        instr_ready,
  input  logic        credit_return,
  input  logic [19:0] expected,
  input  logic        out_valid,
  input  logic        vcc_wr_en,
  input  logic        vgpr_wr_en,
  input  logic        sgpr_wr_en,
  input  logic        illegal_instr,
  input  src_sel_e    source1_mux_select,
  input  src_sel_e    source2_mux_select,
  input  src_sel_e    source3_mux_select,
  input  logic        vgpr_source1_rd_en,
  input  logic        vgpr_source2_rd_en,
  input  logic        vgpr_source3_rd_en,
  output int          value_errs,
  output int          flow_errs,
  output int          pending,
  output int          results
);

  logic [19:0] exp_q[$]; // Expected fields in acceptance order
  logic [19:0] last_fields; // Fields of the latest result
  logic        accept_q;
  logic        reset_q;
  int          credit_model;
  int          n_value;
  int          n_flow;
  int          n_pending;
  int          n_results;

  assign value_errs = n_value;
  assign flow_errs  = n_flow;
  assign pending    = n_pending;
  assign results    = n_results;

  function automatic int bit_mismatch(input string name, input logic exp_val,
                                      input logic act_val);
    if (act_val === exp_val)
      return 0;
    $display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp_val, act_val);
    return 1;
  endfunction

  function automatic int sel_mismatch(input string name, input logic [3:0] exp_val,
                                      input logic [3:0] act_val);
    if (act_val === exp_val)
      return 0;
    $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    return 1;
  endfunction

  task automatic enables_low();
    n_value += bit_mismatch("vcc_wr_en", 1'b0, vcc_wr_en);
    n_value += bit_mismatch("vgpr_wr_en", 1'b0, vgpr_wr_en);
    n_value += bit_mismatch("sgpr_wr_en", 1'b0, sgpr_wr_en);
    n_value += bit_mismatch("illegal_instr", 1'b0, illegal_instr);
    n_value += bit_mismatch("vgpr_source1_rd_en", 1'b0, vgpr_source1_rd_en);
    n_value += bit_mismatch("vgpr_source2_rd_en", 1'b0, vgpr_source2_rd_en);
    n_value += bit_mismatch("vgpr_source3_rd_en", 1'b0, vgpr_source3_rd_en);
  endtask

  task automatic check_idle();
    n_value += bit_mismatch("out_valid", 1'b0, out_valid);
    enables_low();
    n_value += bit_mismatch("instr_ready", 1'b1, instr_ready); // Credits full
  endtask

  // Between results the selects keep the last decoded values
  task automatic hold_between_results(input logic [19:0] last);
    enables_low();
    if (n_results != 0)
    begin
      n_value += sel_mismatch("source1_mux_select", last[15:12], source1_mux_select);
      n_value += sel_mismatch("source2_mux_select", last[11:8], source2_mux_select);
      n_value += sel_mismatch("source3_mux_select", last[7:4], source3_mux_select);
    end
  endtask

  // Write flags in [19:16], selects in [15:4], read enables in [2:0]
  task automatic compare_result(input logic [19:0] exp_fields);
    n_value += bit_mismatch("vcc_wr_en", exp_fields[19], vcc_wr_en);
    n_value += bit_mismatch("vgpr_wr_en", exp_fields[18], vgpr_wr_en);
    n_value += bit_mismatch("sgpr_wr_en", exp_fields[17], sgpr_wr_en);
    n_value += bit_mismatch("illegal_instr", exp_fields[16], illegal_instr);
    n_value += sel_mismatch("source1_mux_select", exp_fields[15:12], source1_mux_select);
    n_value += sel_mismatch("source2_mux_select", exp_fields[11:8], source2_mux_select);
    n_value += sel_mismatch("source3_mux_select", exp_fields[7:4], source3_mux_select);
    n_value += bit_mismatch("vgpr_source1_rd_en", exp_fields[2], vgpr_source1_rd_en);
    n_value += bit_mismatch("vgpr_source2_rd_en", exp_fields[1], vgpr_source2_rd_en);
    n_value += bit_mismatch("vgpr_source3_rd_en", exp_fields[0], vgpr_source3_rd_en);
    n_results++;
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      if (reset_q === 1'b1)
        check_idle(); // Values left by the previous reset edge
      else
      begin
        n_value   = 0;
        n_flow    = 0;
        n_results = 0;
      end
      exp_q.delete();
      accept_q     = 1'b0;
      credit_model = `SIMD_CREDITS;
    end
    else
    begin
      n_flow += bit_mismatch("instr_ready", credit_model != 0, instr_ready);
      n_flow += bit_mismatch("out_valid", accept_q, out_valid); // One cycle latency
      if (out_valid && exp_q.size() != 0)
      begin
        last_fields = exp_q.pop_front();
        compare_result(last_fields);
      end
      else if (out_valid)
      begin
        $display("Result at %0t has no accepted instruction behind it", $time);
        n_flow++;
      end
      else
        hold_between_results(last_fields);
      accept_q = instr_valid && instr_ready;
      if (accept_q)
        exp_q.push_back(expected);
      credit_model = credit_model + int'(credit_return) - int'(accept_q);
    end
    reset_q   = reset;
    n_pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- verification/decode_stim.txt
// Word 0 is the number of instruction lines that follow, in hex
// instr_dest_src1_src2_src3_wr_sel1_sel2_sel3_rd, wr = vcc vgpr sgpr illegal, rd = 0 s1 s2 s3
1C
// VGPR write only, sources cover every class
01000001_000_800_7FF_000_4_2_0_1_4
02ABC01B_000_C05_9FF_3FF_4_3_2_1_2
0200001A_000_E01_E02_E04_4_4_5_6_0
02000014_000_E08_E10_E20_4_7_8_9_0
02000009_000_E40_E80_800_4_A_B_2_1
02000018_000_400_E03_F00_4_F_F_F_0
02000013_000_BFF_A00_C00_4_2_2_3_6
02000000_000_DFF_001_8AB_4_3_1_2_1
04000169_000_800_801_802_4_2_2_2_7
04000148_C10_7FF_7FF_7FF_6_0_0_0_0
0400011B_E01_000_001_002_C_1_1_1_0
0400016A_000_E00_7FE_E81_4_F_F_F_0
// VOPC compares and VOP2 carry ops
03000082_000_800_C00_000_8_2_3_1_4
030000C7_C00_801_802_7FF_8_2_2_0_6
02000025_000_800_800_800_C_2_2_2_7
02000026_000_E01_800_000_C_4_2_1_2
02000027_000_000_E01_800_C_1_4_2_1
02000028_000_800_E02_E01_C_2_5_4_4
// VOP3A compares with destination override
04000081_000_800_801_C01_A_2_2_3_6
040000C4_E01_800_801_000_8_2_2_1_6
04000086_C20_C00_800_E80_2_3_2_B_2
040000C0_800_800_800_800_A_2_2_2_7
// Unlisted opcodes and formats
01000002_000_800_800_800_1_2_2_2_7
020000AA_000_000_000_000_1_1_1_1_0
03000025_000_E08_E10_E40_1_7_8_A_0
040001FF_E01_800_000_C00_1_2_1_3_4
05000001_000_7FF_800_9A0_1_0_2_2_3
00000000_C00_E20_C10_8FF_1_9_3_2_1

//--- verification/tb_simd_instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_simd_instr_decoder
  import simd_decode_pkg::*;
();

  localparam int max_lines  = 64;
  localparam int wait_limit = 64; // Cycles allowed for any single wait

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic        instr_ready;
  instr_t      instr;
  addr_t       sgpr_dest_addr;
  addr_t       source1_addr;
  addr_t       source2_addr;
  addr_t       source3_addr;
  logic        credit_return;
  logic        out_valid;
  logic        vcc_wr_en;
  logic        vgpr_wr_en;
  logic        sgpr_wr_en;
  logic        illegal_instr;
  src_sel_e    source1_mux_select;
  src_sel_e    source2_mux_select;
  src_sel_e    source3_mux_select;
  logic        vgpr_source1_rd_en;
  logic        vgpr_source2_rd_en;
  logic        vgpr_source3_rd_en;
  logic [19:0] expected;
  logic [99:0] stim_mem [0:max_lines];
  logic        hold_credits;
  logic        hold_failed;
  int          owed; // Results consumed but not yet credited
  int          other_errs;
  int          value_errs;
  int          flow_errs;
  int          pending;
  int          results;

  simd_instr_decoder u_simd_instr_decoder (.*);

  decode_checker u_decode_checker (.*);

  always #2 clk = ~clk; // 4 ns period

  // Downstream consumer, returns one credit per result after a random gap
  initial
  begin : credit_return_model
    int   gap;
    logic grant;
    void'($urandom(32'h169ee629));
    credit_return = 1'b0;
    owed          = 0;
    gap           = 0;
    forever
    begin
      @(posedge clk);
      grant = 1'b0;
      if (reset)
        gap = 0;
      else if (gap != 0)
        gap--;
      else if (owed != 0 && !hold_credits)
      begin
        grant = 1'b1;
        gap   = $urandom_range(5, 0);
      end
      credit_return <= grant;
      owed          <= reset ? 0 : owed + int'(out_valid) - int'(grant);
    end
  end

  // Keep every credit until the decoder stalls, then let them flow
  initial
  begin : credit_hold
    int waited;
    hold_credits = 1'b1;
    hold_failed  = 1'b0;
    waited       = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end
    while ((reset || instr_ready) && waited < wait_limit);
    if (waited >= wait_limit)
    begin
      $display("instr_ready stayed high with all credits outstanding");
      hold_failed = 1'b1;
    end
    repeat (3) @(posedge clk);
    hold_credits <= 1'b0;
  end

  initial
  begin : main_sequence
    int   i;
    int   n_lines;
    int   waited;
    logic accepted;
    logic aborted;
    clk            = 1'b0;
    reset          = 1'b1;
    instr_valid    = 1'b0;
    instr          = '0;
    sgpr_dest_addr = '0;
    source1_addr   = '0;
    source2_addr   = '0;
    source3_addr   = '0;
    expected       = '0;
    other_errs     = 0;
    aborted        = 1'b0;
    $readmemh("verification/decode_stim.txt", stim_mem);
    n_lines = int'(stim_mem[0][31:0]); // Word 0 is the line count
    if (n_lines < 1 || n_lines > max_lines)
    begin
      $display("Stim file gives an unusable line count of %0d", n_lines);
      other_errs++;
      aborted = 1'b1;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (i = 1; i <= n_lines && !aborted; i++)
    begin
      {instr, sgpr_dest_addr, source1_addr, source2_addr, source3_addr,
       expected} <= stim_mem[i];
      instr_valid <= 1'b1;
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && !aborted)
      begin
        @(posedge clk);
        waited++;
        if (instr_ready)
          accepted = 1'b1; // Held until the decoder grants it
        else if (waited >= wait_limit)
        begin
          $display("Timeout: line %0d was not accepted within %0d cycles", i, wait_limit);
          other_errs++;
          aborted = 1'b1;
        end
      end
    end
    instr_valid <= 1'b0;

    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (pending != 0 && waited < wait_limit);
    if (pending != 0)
    begin
      $display("Timeout: %0d results still outstanding", pending);
      other_errs++;
    end
    repeat (2) @(negedge clk);
    if (results != n_lines)
    begin
      $display("Saw %0d results for %0d instructions", results, n_lines);
      other_errs++;
    end
    if (hold_failed)
      other_errs++;

    $display("Errors: value %0d, flow %0d, other %0d", value_errs, flow_errs, other_errs);
    if (value_errs + flow_errs + other_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
